// File: run_sim.sh
#!/bin/sh
# build and run the dcache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module tb_dcache --Mdir obj_dir -o tb_dcache -f sim.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_dcache
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi
exit 0

// File: sim.f
source/dcache_pkg.sv
source/dcache_tag_store.sv
source/dcache_data_store.sv
source/dcache_mem_port.sv
source/dcache_ctrl.sv
source/dcache_top.sv
tests/tb_clock.sv
tests/tb_mem_model.sv
tests/tb_dcache.sv

// File: source/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  dcache_pkg::cpu_req_t  cpu_req,
    input  logic                  cpu_req_valid,
    output logic                  cpu_req_ready,
    output dcache_pkg::cpu_resp_t cpu_resp,
    output logic                  cpu_resp_valid,
    input  logic [1:0]            hit,
    input  logic                  hit_way,
    input  logic                  victim_way,
    input  logic                  victim_dirty,
    input  dcache_pkg::tag_t      victim_tag,
    input  dcache_pkg::line_t     line_way0,
    input  dcache_pkg::line_t     line_way1,
    output dcache_pkg::index_t    rd_index,
    output dcache_pkg::tag_t      cmp_tag,
    output dcache_pkg::index_t    cmp_index,
    output logic                  cpu_wr_valid,
    output logic                  cpu_wr_way,
    output dcache_pkg::offset_t   cpu_wr_offset,
    output dcache_pkg::word_t     cpu_wr_data,
    output dcache_pkg::strb_t     cpu_wr_strb,
    output logic                  update_valid,
    output logic                  update_way,
    output dcache_pkg::tag_t      update_tag,
    output logic                  set_dirty,
    output logic                  clear_dirty,
    output logic                  touch_valid,
    output logic                  touch_way,
    output dcache_pkg::line_t     victim_line,
    output dcache_pkg::mem_cmd_t  mem_cmd,
    output logic                  mem_cmd_valid,
    input  logic                  mem_cmd_ready,
    input  logic                  fill_done,
    input  dcache_pkg::word_t     fill_word
);
    import dcache_pkg::*;

    ctrl_state_e state_q;
    cpu_req_t    req_q;
    logic        way_q;
    logic        any_hit;
    line_t       hit_line;

    assign any_hit = |hit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ctrl_idle;
            way_q   <= 1'b0;
        end else begin
            case (state_q)
                ctrl_idle: begin
                    if (cpu_req_valid) begin
                        state_q <= ctrl_lookup;
                    end
                end
                ctrl_lookup: begin
                    if (any_hit) begin
                        state_q <= ctrl_idle;
                    end else if (mem_cmd_ready) begin
                        // keep the victim way until the refill moves the lru bit
                        state_q <= ctrl_miss_wait;
                        way_q   <= victim_way;
                    end
                end
                ctrl_miss_wait: begin
                    if (fill_done) begin
                        state_q <= ctrl_refill;
                    end
                end
                ctrl_refill: state_q <= ctrl_idle;
                default:     state_q <= ctrl_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_req_valid && cpu_req_ready) begin
            req_q <= cpu_req;
        end
    end

    // RAM reads start on the accepting edge and then hold the request set
    assign cpu_req_ready = (state_q == ctrl_idle);
    assign rd_index      = cpu_req_ready ? cpu_req.addr.index : req_q.addr.index;
    assign cmp_tag       = req_q.addr.tag;
    assign cmp_index     = req_q.addr.index;

    assign hit_line    = hit_way ? line_way1 : line_way0;
    assign victim_line = victim_way ? line_way1 : line_way0;

    assign cpu_resp_valid = (state_q == ctrl_lookup && any_hit) || (state_q == ctrl_refill);
    assign cpu_resp.rdata = (state_q == ctrl_lookup) ? hit_line[req_q.addr.offset] : fill_word;

    // write data merge on hit or after the refill
    assign cpu_wr_valid  = req_q.write && cpu_resp_valid;
    assign cpu_wr_way    = (state_q == ctrl_lookup) ? hit_way : way_q;
    assign cpu_wr_offset = req_q.addr.offset;
    assign cpu_wr_data   = req_q.wdata;
    assign cpu_wr_strb   = req_q.wstrb;

    assign update_valid = (state_q == ctrl_refill);
    assign update_way   = way_q;
    assign update_tag   = req_q.addr.tag;
    assign touch_valid  = cpu_resp_valid;
    assign touch_way    = cpu_wr_way;
    assign set_dirty    = req_q.write;
    assign clear_dirty  = !req_q.write && (state_q == ctrl_refill);

    assign mem_cmd_valid = (state_q == ctrl_lookup) && !any_hit;
    assign mem_cmd.victim_addr = '{
        tag: victim_tag, index: req_q.addr.index, offset: '0, byte_sel: '0};
    assign mem_cmd.refill_addr = '{
        tag: req_q.addr.tag, index: req_q.addr.index, offset: '0, byte_sel: '0};
    assign mem_cmd.writeback = victim_dirty;
    assign mem_cmd.way       = victim_way;
    assign mem_cmd.offset    = req_q.addr.offset;

    // the memory port only finishes a refill that the controller waits for
    assert property (@(posedge clk) disable iff (!rst_n)
        fill_done |-> state_q == ctrl_miss_wait);

endmodule

// File: source/dcache_data_store.sv
`timescale 1ns/1ps

module dcache_data_store (
    input  logic                   clk,
    input  dcache_pkg::index_t     rd_index,
    input  logic                   cpu_wr_valid,
    input  logic                   cpu_wr_way,
    input  dcache_pkg::offset_t    cpu_wr_offset,
    input  dcache_pkg::word_t      cpu_wr_data,
    input  dcache_pkg::strb_t      cpu_wr_strb,
    input  dcache_pkg::fill_beat_t fill_beat,
    input  logic                   fill_valid,
    output dcache_pkg::line_t      line_way0,
    output dcache_pkg::line_t      line_way1
);
    import dcache_pkg::*;

    word_t rd_word [2][line_words];

    for (genvar w = 0; w < 2; w++) begin : g_way
        for (genvar b = 0; b < line_words; b++) begin : g_bank
            word_t ram [num_sets];
            strb_t we;
            word_t wd;

            // refill beats always write the whole word
            always_comb begin
                we = '0;
                wd = cpu_wr_data;
                if (cpu_wr_valid && cpu_wr_way == 1'(w) && cpu_wr_offset == offset_t'(b)) begin
                    we = cpu_wr_strb;
                end else if (fill_valid && fill_beat.way == 1'(w) &&
                             fill_beat.offset == offset_t'(b)) begin
                    we = '1;
                    wd = fill_beat.data;
                end
            end

            always_ff @(posedge clk) begin
                for (int i = 0; i < 4; i++) begin
                    if (we[i]) begin
                        ram[rd_index][8*i +: 8] <= wd[8*i +: 8];
                    end
                end
                rd_word[w][b] <= ram[rd_index];
            end
        end
    end

    always_comb begin
        for (int b = 0; b < line_words; b++) begin
            line_way0[b] = rd_word[0][b];
            line_way1[b] = rd_word[1][b];
        end
    end

    // refill owns the banks until fill_done, the CPU merge comes after
    assert property (@(posedge clk) !(cpu_wr_valid && fill_valid));

endmodule

// File: source/dcache_mem_port.sv
`timescale 1ns/1ps

module dcache_mem_port (
    input  logic                   clk,
    input  logic                   rst_n,
    input  dcache_pkg::mem_cmd_t   cmd,
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    input  dcache_pkg::line_t      victim_line,
    output dcache_pkg::fill_beat_t fill_beat,
    output logic                   fill_valid,
    output logic                   fill_done,
    output dcache_pkg::word_t      fill_word,
    output logic [31:0]            mem_ar_addr,
    output logic                   mem_ar_valid,
    input  logic                   mem_ar_ready,
    input  dcache_pkg::word_t      mem_r_data,
    input  logic                   mem_r_last,
    input  logic                   mem_r_valid,
    output logic                   mem_r_ready,
    output logic [31:0]            mem_aw_addr,
    output logic                   mem_aw_valid,
    input  logic                   mem_aw_ready,
    output dcache_pkg::word_t      mem_w_data,
    output logic                   mem_w_last,
    output logic                   mem_w_valid,
    input  logic                   mem_w_ready,
    input  logic                   mem_b_valid,
    output logic                   mem_b_ready
);
    import dcache_pkg::*;

    port_state_e state_q;
    mem_cmd_t    cmd_q;
    line_t       victim_q;
    offset_t     beat_q;
    logic        last_beat;

    assign last_beat = (beat_q == offset_t'(line_words - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= port_idle;
            beat_q    <= '0;
            fill_done <= 1'b0;
        end else begin
            fill_done <= 1'b0;
            case (state_q)
                port_idle: begin
                    if (cmd_valid) begin
                        beat_q  <= '0;
                        state_q <= cmd.writeback ? port_wb_addr : port_rd_addr;
                    end
                end
                port_wb_addr: begin
                    if (mem_aw_ready) begin
                        state_q <= port_wb_data;
                    end
                end
                port_wb_data: begin
                    // counter wraps back to 0 for the refill
                    if (mem_w_ready) begin
                        beat_q <= beat_q + 1'b1;
                        if (last_beat) begin
                            state_q <= port_wb_resp;
                        end
                    end
                end
                port_wb_resp: begin
                    if (mem_b_valid) begin
                        state_q <= port_rd_addr;
                    end
                end
                port_rd_addr: begin
                    if (mem_ar_ready) begin
                        state_q <= port_rd_data;
                    end
                end
                port_rd_data: begin
                    if (mem_r_valid) begin
                        beat_q <= beat_q + 1'b1;
                        if (mem_r_last) begin
                            state_q   <= port_idle;
                            fill_done <= 1'b1;
                        end
                    end
                end
                default: state_q <= port_idle;
            endcase
        end
    end

    // victim line is captured while the store still shows the lookup read
    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            cmd_q    <= cmd;
            victim_q <= victim_line;
        end
        if (fill_valid && beat_q == cmd_q.offset) begin
            fill_word <= mem_r_data;
        end
    end

    assign cmd_ready    = (state_q == port_idle);
    assign mem_aw_valid = (state_q == port_wb_addr);
    assign mem_aw_addr  = cmd_q.victim_addr;
    assign mem_w_valid  = (state_q == port_wb_data);
    assign mem_w_data   = victim_q[beat_q];
    assign mem_w_last   = mem_w_valid && last_beat;
    assign mem_b_ready  = (state_q == port_wb_resp);
    assign mem_ar_valid = (state_q == port_rd_addr);
    assign mem_ar_addr  = cmd_q.refill_addr;
    assign mem_r_ready  = (state_q == port_rd_data);
    assign fill_valid   = mem_r_valid && mem_r_ready;
    assign fill_beat    = '{way: cmd_q.way, offset: beat_q, data: mem_r_data};

    // memory must end every refill after exactly one line
    assert property (@(posedge clk) disable iff (!rst_n) fill_valid |-> (mem_r_last == last_beat));

endmodule

// File: source/dcache_pkg.sv
package dcache_pkg;

    // fixed geometry of 2 ways, 128 sets, 32-byte lines
    localparam int line_words = 8;
    localparam int num_sets   = 128;

    typedef logic [2:0]  offset_t;
    typedef logic [6:0]  index_t;
    typedef logic [19:0] tag_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;

    // word 0 sits at the low end of the line
    typedef word_t [line_words-1:0] line_t;

    // byte address split as tag | index | word offset | byte
    typedef struct packed {
        tag_t       tag;
        index_t     index;
        offset_t    offset;
        logic [1:0] byte_sel;
    } cache_addr_t;

    typedef struct packed {
        cache_addr_t addr;
        word_t       wdata;
        strb_t       wstrb;
        logic        write;
    } cpu_req_t;

    typedef struct packed {
        word_t rdata;
    } cpu_resp_t;

    // miss command from controller to memory port
    typedef struct packed {
        cache_addr_t victim_addr;
        cache_addr_t refill_addr;
        logic        writeback;
        logic        way;
        offset_t     offset;
    } mem_cmd_t;

    typedef struct packed {
        logic    way;
        offset_t offset;
        word_t   data;
    } fill_beat_t;

    typedef enum logic [1:0] {
        ctrl_idle,
        ctrl_lookup,
        ctrl_miss_wait,
        ctrl_refill
    } ctrl_state_e;

    typedef enum logic [2:0] {
        port_idle,
        port_wb_addr,
        port_wb_data,
        port_wb_resp,
        port_rd_addr,
        port_rd_data
    } port_state_e;

endpackage

// File: source/dcache_tag_store.sv
`timescale 1ns/1ps

module dcache_tag_store (
    input  logic               clk,
    input  logic               rst_n,
    input  dcache_pkg::index_t rd_index,
    input  logic               update_valid,
    input  logic               update_way,
    input  dcache_pkg::tag_t   update_tag,
    input  logic               set_dirty,
    input  logic               clear_dirty,
    input  logic               touch_valid,
    input  logic               touch_way,
    input  dcache_pkg::tag_t   cmp_tag,
    input  dcache_pkg::index_t cmp_index,
    output logic [1:0]         hit,
    output logic               hit_way,
    output logic               victim_way,
    output logic               victim_dirty,
    output dcache_pkg::tag_t   victim_tag
);
    import dcache_pkg::*;

    tag_t                tag_ram [2][num_sets];
    tag_t                tag_rd  [2];
    logic [num_sets-1:0] valid_q [2];
    logic [num_sets-1:0] dirty_q [2];
    logic [num_sets-1:0] lru_q;

    // tag RAMs, written at the request index
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (update_valid && update_way == 1'(w)) begin
                tag_ram[w][cmp_index] <= update_tag;
            end
            tag_rd[w] <= tag_ram[w][rd_index];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < 2; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
            lru_q <= '0;
        end else begin
            if (update_valid) begin
                valid_q[update_way][cmp_index] <= 1'b1;
            end
            if (touch_valid) begin
                // lru bit points at the way not touched last
                lru_q[cmp_index] <= ~touch_way;
                if (set_dirty) begin
                    dirty_q[touch_way][cmp_index] <= 1'b1;
                end else if (clear_dirty) begin
                    dirty_q[touch_way][cmp_index] <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit[w] = valid_q[w][cmp_index] && (tag_rd[w] == cmp_tag);
        end
    end

    assign hit_way      = hit[1];
    assign victim_way   = lru_q[cmp_index];
    assign victim_dirty = valid_q[victim_way][cmp_index] && dirty_q[victim_way][cmp_index];
    assign victim_tag   = tag_rd[victim_way];

    // a tag is only allocated after a miss, so never twice in one set
    assert property (@(posedge clk) disable iff (!rst_n) !(&hit));

endmodule

// File: source/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  dcache_pkg::cpu_req_t  cpu_req,
    input  logic                  cpu_req_valid,
    output logic                  cpu_req_ready,
    output dcache_pkg::cpu_resp_t cpu_resp,
    output logic                  cpu_resp_valid,
    output logic [31:0]           mem_ar_addr,
    output logic                  mem_ar_valid,
    input  logic                  mem_ar_ready,
    input  dcache_pkg::word_t     mem_r_data,
    input  logic                  mem_r_last,
    input  logic                  mem_r_valid,
    output logic                  mem_r_ready,
    output logic [31:0]           mem_aw_addr,
    output logic                  mem_aw_valid,
    input  logic                  mem_aw_ready,
    output dcache_pkg::word_t     mem_w_data,
    output logic                  mem_w_last,
    output logic                  mem_w_valid,
    input  logic                  mem_w_ready,
    input  logic                  mem_b_valid,
    output logic                  mem_b_ready
);
    import dcache_pkg::*;

    // store control from the controller
    index_t     rd_index;
    index_t     cmp_index;
    tag_t       cmp_tag;
    tag_t       update_tag;
    offset_t    cpu_wr_offset;
    word_t      cpu_wr_data;
    strb_t      cpu_wr_strb;
    logic       cpu_wr_valid;
    logic       cpu_wr_way;
    logic       update_valid;
    logic       update_way;
    logic       set_dirty;
    logic       clear_dirty;
    logic       touch_valid;
    logic       touch_way;

    // lookup results
    logic [1:0] hit;
    logic       hit_way;
    logic       victim_way;
    logic       victim_dirty;
    tag_t       victim_tag;
    line_t      line_way0;
    line_t      line_way1;
    line_t      victim_line;

    // miss handling
    mem_cmd_t   mem_cmd;
    logic       mem_cmd_valid;
    logic       mem_cmd_ready;
    logic       fill_done;
    logic       fill_valid;
    word_t      fill_word;
    fill_beat_t fill_beat;

    dcache_ctrl u_ctrl (.*);

    dcache_tag_store u_tag_store (.*);

    dcache_data_store u_data_store (.*);

    dcache_mem_port u_mem_port (
        .cmd       (mem_cmd),
        .cmd_valid (mem_cmd_valid),
        .cmd_ready (mem_cmd_ready),
        .*
    );

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held low for the first 3 rising edges
    initial begin
        rst_n <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: tests/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;
    import dcache_pkg::*;

    localparam int fill_ops       = 2;
    localparam int write_hit_ops  = 2;
    localparam int lru_ops        = 6;
    localparam int evict_ops      = 4;
    localparam int random_ops     = 60;
    localparam int num_requests   = fill_ops + write_hit_ops + lru_ops + evict_ops + random_ops;
    localparam int timeout_cycles = 200 * num_requests;

    logic        clk;
    logic        rst_n;
    cpu_req_t    cpu_req;
    logic        cpu_req_valid;
    logic        cpu_req_ready;
    cpu_resp_t   cpu_resp;
    logic        cpu_resp_valid;
    logic [31:0] mem_ar_addr;
    logic        mem_ar_valid;
    logic        mem_ar_ready;
    word_t       mem_r_data;
    logic        mem_r_last;
    logic        mem_r_valid;
    logic        mem_r_ready;
    logic [31:0] mem_aw_addr;
    logic        mem_aw_valid;
    logic        mem_aw_ready;
    word_t       mem_w_data;
    logic        mem_w_last;
    logic        mem_w_valid;
    logic        mem_w_ready;
    logic        mem_b_valid;
    logic        mem_b_ready;
    int          rd_bursts;
    int          wr_bursts;

    logic [4:0]  go = 5'h1f;
    logic        stall_en;
    logic [31:0] stall_lfsr = 32'h0c7d_084f;
    logic [31:0] stim_lfsr = 32'h0c7d_084f;

    // what the CPU should see at every word of the model memory
    word_t       ref_mem [16384];

    tb_clock clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    tb_mem_model mem_model (.*);

    dcache_top uut (.*);

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], stim_lfsr[0]};
            stim_lfsr = lfsr_step(stim_lfsr);
        end
    endtask

    // one bit per memory channel each cycle
    always @(posedge clk) begin
        logic [31:0] s;
        logic [4:0]  bits;
        s = stall_lfsr;
        for (int i = 0; i < 5; i++) begin
            bits[i] = s[0];
            s = lfsr_step(s);
        end
        stall_lfsr <= s;
        go         <= stall_en ? bits : 5'h1f;
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAILED at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    function automatic cache_addr_t make_addr(input int tag, input int index, input int offset);
        cache_addr_t a;
        a.tag      = tag_t'(tag);
        a.index    = index_t'(index);
        a.offset   = offset_t'(offset);
        a.byte_sel = '0;
        return a;
    endfunction

    // tags stay below 16 so every address lands in the model
    function automatic logic [13:0] word_index(input cache_addr_t a);
        return {a.tag[3:0], a.index, a.offset};
    endfunction

    // called on a rising edge and returns on the response edge
    task automatic cpu_access(input logic write, input cache_addr_t a, input word_t wdata,
                              input strb_t wstrb, output word_t rdata, output int lat);
        cpu_req       <= '{addr: a, wdata: wdata, wstrb: wstrb, write: write};
        cpu_req_valid <= 1'b1;
        @(posedge clk);
        // the cache is idle again one cycle after each response
        check_flag("cpu_req_ready", cpu_req_ready, 1'b1);
        check_flag("cpu_resp_valid", cpu_resp_valid, 1'b0);
        cpu_req_valid <= 1'b0;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
            check_flag("cpu_req_ready", cpu_req_ready, 1'b0);
        end while (!cpu_resp_valid);
        rdata = cpu_resp.rdata;
    endtask

    task automatic read_check(input cache_addr_t a, output int lat);
        word_t got;
        cpu_access(1'b0, a, '0, '0, got, lat);
        check_word("cpu_resp.rdata", got, ref_mem[word_index(a)]);
    endtask

    task automatic write_word(input cache_addr_t a, input word_t d, input strb_t s,
                              output int lat);
        word_t       ignored;
        logic [13:0] w;
        w = word_index(a);
        for (int i = 0; i < 4; i++) begin
            if (s[i]) begin
                ref_mem[w][8*i +: 8] = d[8*i +: 8];
            end
        end
        cpu_access(1'b1, a, d, s, ignored, lat);
    endtask

    task automatic fill_on_miss();
        int rd0;
        int lat;
        rd0 = rd_bursts;
        read_check(make_addr(1, 3, 2), lat);
        check_count("rd_bursts", rd_bursts, rd0 + 1);
        // a second word of the same line comes from the fill
        read_check(make_addr(1, 3, 5), lat);
        check_count("rd_bursts", rd_bursts, rd0 + 1);
        check_count("hit latency", lat, 1);
    endtask

    task automatic partial_write_hit();
        int wr0;
        int lat;
        wr0 = wr_bursts;
        write_word(make_addr(1, 3, 2), 32'hdead_beef, 4'b0101, lat);
        check_count("hit latency", lat, 1);
        read_check(make_addr(1, 3, 2), lat);
        check_count("wr_bursts", wr_bursts, wr0);
    endtask

    task automatic lru_replacement();
        int rd0;
        int lat;
        rd0 = rd_bursts;
        read_check(make_addr(2, 10, 0), lat);
        read_check(make_addr(3, 10, 1), lat);
        // touch tag 2 so tag 3 becomes the victim
        read_check(make_addr(2, 10, 6), lat);
        read_check(make_addr(4, 10, 3), lat);
        check_count("rd_bursts", rd_bursts, rd0 + 3);
        read_check(make_addr(2, 10, 7), lat);
        check_count("rd_bursts", rd_bursts, rd0 + 3);
        read_check(make_addr(3, 10, 4), lat);
        check_count("rd_bursts", rd_bursts, rd0 + 4);
    endtask

    task automatic dirty_eviction();
        cache_addr_t a;
        logic [31:0] d;
        int          wr0;
        int          lat;
        wr0 = wr_bursts;
        a = make_addr(5, 20, 1);
        rand_bits(32, d);
        write_word(a, d, 4'hf, lat);
        read_check(make_addr(6, 20, 0), lat);
        read_check(make_addr(7, 20, 4), lat);
        check_count("wr_bursts", wr_bursts, wr0 + 1);
        check_word("mem_model.mem", mem_model.mem[word_index(a)], ref_mem[word_index(a)]);
        read_check(a, lat);
    endtask

    task automatic random_mix();
        cache_addr_t a;
        logic [31:0] w;
        logic [31:0] s;
        logic [31:0] t;
        logic [31:0] o;
        logic [31:0] st;
        logic [31:0] d;
        int          lat;
        stall_en <= 1'b1;
        // four tags over four sets, so misses and evictions are frequent
        for (int n = 0; n < random_ops; n++) begin
            rand_bits(1, w);
            rand_bits(2, s);
            rand_bits(2, t);
            rand_bits(3, o);
            a = make_addr(8 + int'(t), 40 + int'(s), int'(o));
            if (w[0]) begin
                rand_bits(4, st);
                rand_bits(32, d);
                write_word(a, d, st[3:0], lat);
            end else begin
                read_check(a, lat);
            end
        end
        stall_en <= 1'b0;
    endtask

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
        abort_run();
    end

    initial begin
        cpu_req       <= '0;
        cpu_req_valid <= 1'b0;
        stall_en      <= 1'b0;
        @(posedge rst_n);
        @(posedge clk);
        for (int i = 0; i < 16384; i++) begin
            ref_mem[14'(i)] = mem_model.mem[14'(i)];
        end
        fill_on_miss();
        partial_write_hit();
        lru_replacement();
        dirty_eviction();
        random_mix();
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: tests/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [4:0]        go,
    input  logic [31:0]       mem_ar_addr,
    input  logic              mem_ar_valid,
    output logic              mem_ar_ready,
    output dcache_pkg::word_t mem_r_data,
    output logic              mem_r_last,
    output logic              mem_r_valid,
    input  logic              mem_r_ready,
    input  logic [31:0]       mem_aw_addr,
    input  logic              mem_aw_valid,
    output logic              mem_aw_ready,
    input  dcache_pkg::word_t mem_w_data,
    input  logic              mem_w_last,
    input  logic              mem_w_valid,
    output logic              mem_w_ready,
    output logic              mem_b_valid,
    input  logic              mem_b_ready,
    output int                rd_bursts,
    output int                wr_bursts
);
    import dcache_pkg::*;

    // 64 kB of backing store, indexed by word address
    word_t       mem [16384];
    logic [10:0] rd_line;
    logic [10:0] wr_line;
    logic [2:0]  rd_beat;
    logic [2:0]  wr_beat;
    logic        rd_active;
    logic        wr_active;
    logic        b_pending;

    // every word starts as a hash of its full address
    initial begin
        for (int i = 0; i < 16384; i++) begin
            mem[14'(i)] <= 32'h9e37_79b9 * (i + 1);
        end
    end

    assign mem_r_data = mem[{rd_line, rd_beat}];
    assign mem_r_last = (rd_beat == 3'd7);

    // read side, go[0] gates ar_ready and go[1] gates r_valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_ar_ready <= 1'b0;
            mem_r_valid  <= 1'b0;
            rd_active    <= 1'b0;
            rd_line      <= '0;
            rd_beat      <= '0;
            rd_bursts    <= 0;
        end else if (mem_ar_valid && mem_ar_ready) begin
            mem_ar_ready <= 1'b0;
            rd_active    <= 1'b1;
            rd_line      <= mem_ar_addr[15:5];
            rd_beat      <= '0;
            rd_bursts    <= rd_bursts + 1;
        end else if (rd_active) begin
            if (mem_r_valid && mem_r_ready) begin
                rd_beat     <= rd_beat + 1'b1;
                rd_active   <= !mem_r_last;
                mem_r_valid <= !mem_r_last && go[1];
            end else if (!mem_r_valid) begin
                mem_r_valid <= go[1];
            end
        end else begin
            mem_ar_ready <= go[0];
        end
    end

    // write side, go[2..4] gate aw_ready, w_ready and b_valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_aw_ready <= 1'b0;
            mem_w_ready  <= 1'b0;
            mem_b_valid  <= 1'b0;
            wr_active    <= 1'b0;
            b_pending    <= 1'b0;
            wr_line      <= '0;
            wr_beat      <= '0;
            wr_bursts    <= 0;
        end else if (mem_aw_valid && mem_aw_ready) begin
            mem_aw_ready <= 1'b0;
            wr_active    <= 1'b1;
            wr_line      <= mem_aw_addr[15:5];
            wr_beat      <= '0;
            wr_bursts    <= wr_bursts + 1;
        end else if (wr_active) begin
            if (mem_w_valid && mem_w_ready) begin
                wr_beat     <= wr_beat + 1'b1;
                wr_active   <= !mem_w_last;
                b_pending   <= mem_w_last;
                mem_w_ready <= 1'b0;
            end else begin
                mem_w_ready <= go[3];
            end
        end else if (b_pending) begin
            if (mem_b_valid && mem_b_ready) begin
                b_pending   <= 1'b0;
                mem_b_valid <= 1'b0;
            end else if (!mem_b_valid) begin
                mem_b_valid <= go[4];
            end
        end else begin
            mem_aw_ready <= go[2];
        end
    end

    always @(posedge clk) begin
        if (mem_w_valid && mem_w_ready) begin
            mem[{wr_line, wr_beat}] <= mem_w_data;
        end
    end

endmodule
